//--- src/rv_ex_settings.svh
`ifndef RV_EX_SETTINGS_SVH
`define RV_EX_SETTINGS_SVH

// Data path width
`define XLEN   32

// Register index width, 32 architectural registers
`define REG_AW 5

`endif

//--- src/rv_types_pkg.sv
`include "rv_ex_settings.svh"

package rv_types_pkg;

    typedef logic [`XLEN-1:0]   word_t;     // Operand, PC, immediate or result
    typedef logic [`REG_AW-1:0] reg_addr_t; // Register index, x0 reads as zero

    // ALU operation, bit 3 mirrors funct7[5], low bits follow funct3
    typedef enum logic [3:0] {
        ADD    = 4'b0000,
        SLL    = 4'b0001,
        SLT    = 4'b0010,
        SLTU   = 4'b0011,
        XOR    = 4'b0100,
        SRL    = 4'b0101,
        OR     = 4'b0110,
        AND    = 4'b0111,
        SUB    = 4'b1000,
        SRA    = 4'b1101,
        PASS_B = 4'b1111   // Forward B untouched
    } alu_ctrl_t;

    // Operand class, decides what feeds ALU inputs A and B
    typedef enum logic [2:0] {
        MEM    = 3'd0,     // Load/store address
        BRANCH = 3'd1,     // Compare rs1 with rs2
        ARITH  = 3'd2,     // R or I type
        JAL    = 3'd3,
        LUI    = 3'd4,
        AUIPC  = 3'd5,
        JALR   = 3'd7      // Code 6 unused
    } alu_op_t;

    // Branch condition, same codes as funct3 of the B format
    typedef enum logic [2:0] {
        EQ  = 3'b000,
        NE  = 3'b001,
        LT  = 3'b100,
        GE  = 3'b101,
        LTU = 3'b110,
        GEU = 3'b111
    } br_cond_t;

endpackage

//--- src/rv_pipe_pkg.sv
package rv_pipe_pkg;

    // Controls carried through execute toward MEM and WB
    typedef struct packed {
        logic                    alu_src;    // ARITH takes B from imm
        rv_types_pkg::alu_op_t   alu_op;     // Operand class
        rv_types_pkg::alu_ctrl_t alu_ctrl;   // ALU operation
        logic                    branch;     // Conditional branch
        rv_types_pkg::br_cond_t  br_cond;
        logic                    mem_write;  // Store
        logic                    mem_read;   // Load
        logic                    reg_write;  // Writes rd in WB
        logic                    mem_to_reg; // WB data comes from memory
        rv_types_pkg::reg_addr_t rd;
    } ex_ctrl_t;

    // Instruction as issued by decode
    typedef struct packed {
        rv_types_pkg::word_t     pc;
        rv_types_pkg::word_t     imm;        // Sign-extended immediate
        rv_types_pkg::reg_addr_t rs1_addr;
        rv_types_pkg::reg_addr_t rs2_addr;
        rv_types_pkg::word_t     rs1_data;   // Register file read
        rv_types_pkg::word_t     rs2_data;
        ex_ctrl_t                ctrl;
    } id_ex_t;

    // Write-back candidate from a later stage
    typedef struct packed {
        logic                    reg_write;
        rv_types_pkg::reg_addr_t rd;
        rv_types_pkg::word_t     data;       // Value that rd will receive
    } fwd_t;

    // Execute result handed to the EX/MEM register
    typedef struct packed {
        logic                    mem_write;
        logic                    mem_read;
        logic                    reg_write;
        logic                    mem_to_reg;
        rv_types_pkg::reg_addr_t rd;
        rv_types_pkg::word_t     alu_result; // Also link address for jumps
        rv_types_pkg::word_t     store_data; // Forwarded rs2
        logic                    redirect;   // Fetch must restart at target
        rv_types_pkg::word_t     target;
    } ex_mem_t;

endpackage

//--- src/alu.sv
`timescale 1ns/1ps

module alu (
    input  rv_types_pkg::alu_ctrl_t alu_ctrl,
    input  rv_types_pkg::word_t     a,
    input  rv_types_pkg::word_t     b,
    output rv_types_pkg::word_t     result,
    output logic                    zero,     // a equals b
    output logic                    lt,       // Signed a < b
    output logic                    ltu       // Unsigned a < b
);
    localparam int W   = $bits(rv_types_pkg::word_t);
    localparam int SHW = $clog2(W);

    logic [W:0]          sub_ext;  // a - b with borrow on top
    rv_types_pkg::word_t diff;
    logic [SHW-1:0]      shamt;

    // One subtractor serves SUB, SLT(U) and the branch flags
    assign sub_ext = {1'b0, a} - {1'b0, b};
    assign diff    = sub_ext[W-1:0];
    assign shamt   = b[SHW-1:0];      // Low 5 bits only

    assign zero = (diff == '0);
    assign ltu  = sub_ext[W];         // Borrow out
    // Differing signs decide directly, else the difference sign does
    assign lt   = (a[W-1] != b[W-1]) ? a[W-1] : diff[W-1];

    always_comb
    begin
        case (alu_ctrl)
            rv_types_pkg::ADD:    result = a + b;
            rv_types_pkg::SUB:    result = diff;
            rv_types_pkg::SLL:    result = a << shamt;
            rv_types_pkg::SLT:    result = rv_types_pkg::word_t'(lt);
            rv_types_pkg::SLTU:   result = rv_types_pkg::word_t'(ltu);
            rv_types_pkg::XOR:    result = a ^ b;
            rv_types_pkg::SRL:    result = a >> shamt;
            rv_types_pkg::SRA:    result = $signed(a) >>> shamt; // Sign fill
            rv_types_pkg::OR:     result = a | b;
            rv_types_pkg::AND:    result = a & b;
            rv_types_pkg::PASS_B: result = b;
            default:              result = '0;  // Unused codes
        endcase
    end

endmodule

//--- src/forward_unit.sv
`timescale 1ns/1ps

module forward_unit (
    input  rv_pipe_pkg::id_ex_t id_ex,
    input  rv_pipe_pkg::fwd_t   ex_mem_fwd,   // Newest producer
    input  rv_pipe_pkg::fwd_t   mem_wb_fwd,   // Older producer
    output rv_types_pkg::word_t rs1_val,
    output rv_types_pkg::word_t rs2_val
);

    // A later stage will write src, x0 never counts
    function automatic logic hits(rv_pipe_pkg::fwd_t fwd, rv_types_pkg::reg_addr_t src);
        return fwd.reg_write && (fwd.rd != '0) && (fwd.rd == src);
    endfunction

    // EX/MEM first, then MEM/WB, else the register file read
    function automatic rv_types_pkg::word_t pick(rv_types_pkg::reg_addr_t src,
                                                 rv_types_pkg::word_t     rf_data,
                                                 rv_pipe_pkg::fwd_t       near,
                                                 rv_pipe_pkg::fwd_t       far);
        rv_types_pkg::word_t val;
        if (hits(near, src))
            val = near.data;
        else if (hits(far, src))
            val = far.data;
        else
            val = rf_data;
        return val;
    endfunction

    always_comb
    begin
        rs1_val = pick(id_ex.rs1_addr, id_ex.rs1_data, ex_mem_fwd, mem_wb_fwd);
        rs2_val = pick(id_ex.rs2_addr, id_ex.rs2_data, ex_mem_fwd, mem_wb_fwd);
    end

endmodule

//--- src/execute.sv
`timescale 1ns/1ps

module execute (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 stall,     // Hold ID/EX
    input  logic                 flush,     // Load a bubble, wins over stall
    input  rv_pipe_pkg::id_ex_t  id_ex,
    input  rv_types_pkg::word_t  rs1_val,   // Forwarded sources
    input  rv_types_pkg::word_t  rs2_val,
    output rv_pipe_pkg::ex_mem_t ex_out
);
    localparam int W = $bits(rv_types_pkg::word_t);

    rv_pipe_pkg::id_ex_t id_ex_d;           // Issued instruction with forwarded data
    rv_pipe_pkg::id_ex_t id_ex_q;           // ID/EX register
    rv_types_pkg::word_t alu_a;
    rv_types_pkg::word_t alu_b;
    rv_types_pkg::word_t alu_result;
    rv_types_pkg::word_t tgt_base;
    rv_types_pkg::word_t tgt_sum;
    logic                alu_zero;
    logic                alu_lt;
    logic                alu_ltu;
    logic                is_jal;
    logic                is_jalr;
    logic                is_branch;
    logic                cond_true;

    always_comb
    begin
        id_ex_d          = id_ex;
        id_ex_d.rs1_data = rs1_val;
        id_ex_d.rs2_data = rs2_val;
    end

    // All-zero contents form the bubble
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            id_ex_q <= '0;
        else if (flush)
            id_ex_q <= '0;
        else if (!stall)
            id_ex_q <= id_ex_d;             // Stall keeps the old operands too
    end

    // Operand select by class
    always_comb
    begin
        alu_a = id_ex_q.rs1_data;
        alu_b = id_ex_q.imm;
        case (id_ex_q.ctrl.alu_op)
            rv_types_pkg::MEM:    ;         // rs1 + imm
            rv_types_pkg::BRANCH: alu_b = id_ex_q.rs2_data;
            rv_types_pkg::ARITH:  alu_b = id_ex_q.ctrl.alu_src ? id_ex_q.imm : id_ex_q.rs2_data;
            rv_types_pkg::LUI:    alu_a = '0;
            rv_types_pkg::AUIPC:  alu_a = id_ex_q.pc;
            rv_types_pkg::JAL,
            rv_types_pkg::JALR:
            begin
                alu_a = id_ex_q.pc;         // Link address pc + 4
                alu_b = rv_types_pkg::word_t'(4);
            end
            default:
            begin
                alu_a = '0;
                alu_b = '0;
            end
        endcase
    end

    alu u_alu (
        .alu_ctrl (id_ex_q.ctrl.alu_ctrl),
        .a        (alu_a),
        .b        (alu_b),
        .result   (alu_result),
        .zero     (alu_zero),
        .lt       (alu_lt),
        .ltu      (alu_ltu)
    );

    assign is_jal    = (id_ex_q.ctrl.alu_op == rv_types_pkg::JAL);
    assign is_jalr   = (id_ex_q.ctrl.alu_op == rv_types_pkg::JALR);
    // Flags compare rs1 with rs2 only in the BRANCH class
    assign is_branch = id_ex_q.ctrl.branch && (id_ex_q.ctrl.alu_op == rv_types_pkg::BRANCH);

    always_comb
    begin
        case (id_ex_q.ctrl.br_cond)
            rv_types_pkg::EQ:  cond_true = alu_zero;
            rv_types_pkg::NE:  cond_true = !alu_zero;
            rv_types_pkg::LT:  cond_true = alu_lt;
            rv_types_pkg::GE:  cond_true = !alu_lt;
            rv_types_pkg::LTU: cond_true = alu_ltu;
            rv_types_pkg::GEU: cond_true = !alu_ltu;
            default:           cond_true = 1'b0;
        endcase
    end

    // Target adder, separate from the ALU
    assign tgt_base = is_jalr ? id_ex_q.rs1_data : id_ex_q.pc;
    assign tgt_sum  = tgt_base + id_ex_q.imm;

    always_comb
    begin
        ex_out.mem_write  = id_ex_q.ctrl.mem_write;
        ex_out.mem_read   = id_ex_q.ctrl.mem_read;
        ex_out.reg_write  = id_ex_q.ctrl.reg_write;
        ex_out.mem_to_reg = id_ex_q.ctrl.mem_to_reg;
        ex_out.rd         = id_ex_q.ctrl.rd;
        ex_out.alu_result = alu_result;
        ex_out.store_data = id_ex_q.rs2_data;
        ex_out.redirect   = is_jal || is_jalr || (is_branch && cond_true);
        ex_out.target     = is_jalr ? {tgt_sum[W-1:1], 1'b0} : tgt_sum; // JALR clears bit 0
    end

endmodule

//--- src/ex_stage_top.sv
`timescale 1ns/1ps

module ex_stage_top (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 stall,       // From hazard unit
    input  logic                 flush,
    input  rv_pipe_pkg::id_ex_t  id_ex,       // From decode
    input  rv_pipe_pkg::fwd_t    ex_mem_fwd,  // EX/MEM register
    input  rv_pipe_pkg::fwd_t    mem_wb_fwd,  // MEM/WB register, selected WB data
    output rv_pipe_pkg::ex_mem_t ex_out
);

    rv_types_pkg::word_t rs1_val;
    rv_types_pkg::word_t rs2_val;

    // Forwarding resolved at issue, before the ID/EX register
    forward_unit u_forward_unit (
        .id_ex      (id_ex),
        .ex_mem_fwd (ex_mem_fwd),
        .mem_wb_fwd (mem_wb_fwd),
        .rs1_val    (rs1_val),
        .rs2_val    (rs2_val)
    );

    execute u_execute (
        .clk     (clk),
        .rst     (rst),
        .stall   (stall),
        .flush   (flush),
        .id_ex   (id_ex),
        .rs1_val (rs1_val),
        .rs2_val (rs2_val),
        .ex_out  (ex_out)
    );

endmodule

//--- bench/ex_stage_props.sv
`timescale 1ns/1ps

module ex_stage_props (
    input logic                 clk,
    input logic                 rst,
    input logic                 flush,
    input rv_pipe_pkg::id_ex_t  id_ex,
    input rv_types_pkg::word_t  rs1_val,
    input rv_types_pkg::word_t  rs2_val,
    input rv_pipe_pkg::ex_mem_t ex_out
);

    // No memory access, write-back or redirect while in reset
    a_reset_idle: assert property (@(posedge clk)
        rst |-> !(ex_out.mem_write || ex_out.mem_read || ex_out.reg_write || ex_out.redirect))
        else $error("controls active during reset");

    // Flush loads a bubble for the next cycle
    a_flush_bubble: assert property (@(posedge clk) disable iff (rst)
        flush |=> !(ex_out.mem_write || ex_out.mem_read || ex_out.reg_write
                    || ex_out.redirect) && (ex_out.rd == '0))
        else $error("flush did not yield a bubble");

    // Source x0 keeps the register file value, never a forwarded one
    a_x0_rs1: assert property (@(posedge clk) disable iff (rst)
        (id_ex.rs1_addr == '0) |-> (rs1_val == id_ex.rs1_data))
        else $error("rs1 x0 received forwarded data");
    a_x0_rs2: assert property (@(posedge clk) disable iff (rst)
        (id_ex.rs2_addr == '0) |-> (rs2_val == id_ex.rs2_data))
        else $error("rs2 x0 received forwarded data");

endmodule

bind execute ex_stage_props props_i (
    .clk     (clk),
    .rst     (rst),
    .flush   (flush),
    .id_ex   (id_ex),
    .rs1_val (rs1_val),
    .rs2_val (rs2_val),
    .ex_out  (ex_out)
);

//--- bench/ex_stage_tb.sv
`timescale 1ns/1ps

module ex_stage_tb;
    typedef struct packed {
        logic                 rst;
        logic                 stall;
        logic                 flush;
        rv_pipe_pkg::id_ex_t  id_ex;
        rv_pipe_pkg::fwd_t    exf;
        rv_pipe_pkg::fwd_t    wbf;
    } sample_t;                             // Inputs seen by the DUT at one edge

    logic                 clk;
    logic                 rst;
    logic                 stall;
    logic                 flush;
    rv_pipe_pkg::id_ex_t  id_ex;
    rv_pipe_pkg::fwd_t    ex_mem_fwd;
    rv_pipe_pkg::fwd_t    mem_wb_fwd;
    rv_pipe_pkg::ex_mem_t ex_out;
    sample_t              pending[$];
    rv_pipe_pkg::id_ex_t  model_q = '0;     // Model of the ID/EX register
    integer               seed = 49862;
    int                   checks = 0;
    int                   errors = 0;
    int                   err_mark = 0;
    int                   chk_mark = 0;

    ex_stage_top dut_i (.clk(clk), .rst(rst), .stall(stall), .flush(flush), .id_ex(id_ex),
                        .ex_mem_fwd(ex_mem_fwd), .mem_wb_fwd(mem_wb_fwd), .ex_out(ex_out));

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic rv_types_pkg::word_t alu_ref(rv_types_pkg::alu_ctrl_t op,
                                                   rv_types_pkg::word_t a,
                                                   rv_types_pkg::word_t b);
        case (op)
            rv_types_pkg::ADD:    return a + b;
            rv_types_pkg::SUB:    return a - b;
            rv_types_pkg::SLL:    return a << b[4:0];
            rv_types_pkg::SLT:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            rv_types_pkg::SLTU:   return (a < b) ? 32'd1 : 32'd0;
            rv_types_pkg::XOR:    return a ^ b;
            rv_types_pkg::SRL:    return a >> b[4:0];
            rv_types_pkg::SRA:    return $signed(a) >>> b[4:0];
            rv_types_pkg::OR:     return a | b;
            rv_types_pkg::AND:    return a & b;
            rv_types_pkg::PASS_B: return b;
            default:              return '0;
        endcase
    endfunction

    function automatic logic cond_ref(rv_types_pkg::br_cond_t c, rv_types_pkg::word_t a,
                                      rv_types_pkg::word_t b);
        case (c)
            rv_types_pkg::EQ:  return a == b;
            rv_types_pkg::NE:  return a != b;
            rv_types_pkg::LT:  return $signed(a) < $signed(b);
            rv_types_pkg::GE:  return $signed(a) >= $signed(b);
            rv_types_pkg::LTU: return a < b;
            rv_types_pkg::GEU: return a >= b;
            default:           return 1'b0;
        endcase
    endfunction

    // Newest producer first, x0 never forwarded
    function automatic rv_types_pkg::word_t src_ref(rv_types_pkg::reg_addr_t addr,
                                                   rv_types_pkg::word_t rf,
                                                   rv_pipe_pkg::fwd_t e, rv_pipe_pkg::fwd_t w);
        if (addr != 0 && e.reg_write && e.rd == addr)
            return e.data;
        if (addr != 0 && w.reg_write && w.rd == addr)
            return w.data;
        return rf;
    endfunction

    function automatic rv_pipe_pkg::ex_mem_t exp_ex(rv_pipe_pkg::id_ex_t r);
        rv_pipe_pkg::ex_mem_t e;
        rv_types_pkg::word_t  a;
        rv_types_pkg::word_t  b;
        a = r.rs1_data;
        b = r.imm;
        case (r.ctrl.alu_op)
            rv_types_pkg::BRANCH: b = r.rs2_data;
            rv_types_pkg::ARITH:  b = r.ctrl.alu_src ? r.imm : r.rs2_data;
            rv_types_pkg::LUI:    a = '0;
            rv_types_pkg::AUIPC:  a = r.pc;
            rv_types_pkg::JAL, rv_types_pkg::JALR:
            begin
                a = r.pc;
                b = 32'd4;
            end
            default: ;
        endcase
        e.mem_write  = r.ctrl.mem_write;
        e.mem_read   = r.ctrl.mem_read;
        e.reg_write  = r.ctrl.reg_write;
        e.mem_to_reg = r.ctrl.mem_to_reg;
        e.rd         = r.ctrl.rd;
        e.alu_result = alu_ref(r.ctrl.alu_ctrl, a, b);
        e.store_data = r.rs2_data;
        e.redirect   = (r.ctrl.alu_op inside {rv_types_pkg::JAL, rv_types_pkg::JALR})
                       || (r.ctrl.branch && cond_ref(r.ctrl.br_cond, r.rs1_data, r.rs2_data));
        e.target     = r.pc + r.imm;
        if (r.ctrl.alu_op == rv_types_pkg::JALR)
            e.target = (r.rs1_data + r.imm) & ~32'd1;
        return e;
    endfunction

    always @(posedge clk)
        pending.push_back({rst, stall, flush, id_ex, ex_mem_fwd, mem_wb_fwd});

    // Update the model with the edge just taken, then compare mid-cycle
    always @(negedge clk)
    begin
        sample_t              s;
        rv_pipe_pkg::ex_mem_t exp;
        if (pending.size() > 0)
        begin
            s = pending.pop_front();
            if (s.rst || s.flush)
                model_q = '0;
            else if (!s.stall)
            begin
                model_q          = s.id_ex;
                model_q.rs1_data = src_ref(s.id_ex.rs1_addr, s.id_ex.rs1_data, s.exf, s.wbf);
                model_q.rs2_data = src_ref(s.id_ex.rs2_addr, s.id_ex.rs2_data, s.exf, s.wbf);
            end
            exp = exp_ex(model_q);
            checks++;
            if (ex_out !== exp)
            begin
                errors++;
                $display("ERR %0t: ex_out mismatch exp %h got %h", $time, exp, ex_out);
            end
        end
    end

    function automatic rv_pipe_pkg::fwd_t rand_fwd();
        rv_pipe_pkg::fwd_t   f;
        rv_types_pkg::word_t t;
        t           = $random(seed);
        f.reg_write = t[0];
        f.rd        = {3'b0, t[2:1]};          // x0..x3 so hits are common
        f.data      = $random(seed);
        return f;
    endfunction

    function automatic rv_pipe_pkg::id_ex_t make_instr(rv_types_pkg::alu_op_t op,
                                                      rv_types_pkg::alu_ctrl_t ctl);
        rv_pipe_pkg::id_ex_t i;
        rv_types_pkg::word_t t;
        t                = $random(seed);
        i                = '0;
        i.pc             = $random(seed) & ~32'd3;
        i.imm            = $random(seed);
        i.rs1_addr       = t[4:0];
        i.rs2_addr       = t[9:5];
        i.rs1_data       = $random(seed);
        i.rs2_data       = $random(seed);
        i.ctrl.alu_op    = op;
        i.ctrl.alu_ctrl  = ctl;
        i.ctrl.alu_src   = (op == rv_types_pkg::ARITH) && t[10];
        i.ctrl.rd        = t[15:11];
        i.ctrl.reg_write = !(op inside {rv_types_pkg::MEM, rv_types_pkg::BRANCH});
        i.ctrl.branch    = (op == rv_types_pkg::BRANCH);
        return i;
    endfunction

    task automatic drive(rv_pipe_pkg::id_ex_t ins, rv_pipe_pkg::fwd_t e, rv_pipe_pkg::fwd_t w,
                         logic st, logic fl);
        @(posedge clk);
        id_ex      <= ins;
        ex_mem_fwd <= e;
        mem_wb_fwd <= w;
        stall      <= st;
        flush      <= fl;
    endtask

    task automatic end_test(string name);
        repeat (3) drive('0, '0, '0, 1'b0, 1'b0);   // Drain the one-cycle pipe
        repeat (2) @(posedge clk);
        $display("%s: %0d checks, %0d errors", name, checks - chk_mark, errors - err_mark);
        chk_mark = checks;
        err_mark = errors;
    endtask

    initial
    begin
        rv_pipe_pkg::id_ex_t ins;
        rv_pipe_pkg::fwd_t   fe;
        rv_pipe_pkg::fwd_t   fw;
        rv_types_pkg::word_t t;
        int                  waited;
        rv_types_pkg::alu_ctrl_t ops[11];
        rv_types_pkg::br_cond_t  conds[6];
        ops = '{rv_types_pkg::ADD, rv_types_pkg::SUB,
            rv_types_pkg::SLL, rv_types_pkg::SLT, rv_types_pkg::SLTU, rv_types_pkg::XOR,
            rv_types_pkg::SRL, rv_types_pkg::SRA, rv_types_pkg::OR, rv_types_pkg::AND,
            rv_types_pkg::PASS_B};
        conds = '{rv_types_pkg::EQ, rv_types_pkg::NE,
            rv_types_pkg::LT, rv_types_pkg::GE, rv_types_pkg::LTU, rv_types_pkg::GEU};
        rst        = 1'b1;
        stall      = 1'b0;
        flush      = 1'b0;
        id_ex      = '0;
        ex_mem_fwd = '0;
        mem_wb_fwd = '0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        waited = 0;
        while (rst !== 1'b0 && waited < 20)    // Reset release, bounded
        begin
            @(negedge clk);
            waited++;
        end
        if (rst !== 1'b0)
        begin
            $display("Reset never released within 20 cycles");
            $display("TESTS FAILED");
            $finish;
        end
        else
        begin
            // 1 reset bubble, then flush
            drive(make_instr(rv_types_pkg::ARITH, rv_types_pkg::ADD), '0, '0, 1'b0, 1'b0);
            drive(make_instr(rv_types_pkg::ARITH, rv_types_pkg::OR), '0, '0, 1'b0, 1'b1);
            drive(make_instr(rv_types_pkg::MEM, rv_types_pkg::ADD), '0, '0, 1'b1, 1'b1);
            end_test("reset_bubble");
            foreach (ops[k])                   // 2 every ALU operation
                repeat (4) drive(make_instr(rv_types_pkg::ARITH, ops[k]), '0, '0, 1'b0, 1'b0);
            end_test("alu_ops");
            for (int n = 0; n < 40; n++)       // 3 EX/MEM only, MEM/WB only, both, neither
            begin
                ins = make_instr(rv_types_pkg::ARITH, rv_types_pkg::ADD);
                ins.rs1_addr = {3'b0, ins.rs1_addr[1:0]};
                ins.rs2_addr = {3'b0, ins.rs2_addr[1:0]};
                fe = rand_fwd();
                fw = rand_fwd();
                fe.reg_write = (n % 4 == 0) || (n % 4 == 2);
                fw.reg_write = (n % 4 == 1) || (n % 4 == 2);
                fe.rd        = ins.rs1_addr;   // Same address so reg_write alone decides
                fw.rd        = ins.rs1_addr;
                drive(ins, fe, fw, 1'b0, 1'b0);
            end
            end_test("forwarding");
            foreach (conds[k])                 // 4 both sides of each condition
                for (int p = 0; p < 3; p++)
                begin
                    ins = make_instr(rv_types_pkg::BRANCH, rv_types_pkg::SUB);
                    ins.ctrl.br_cond = conds[k];
                    if (p == 0)
                        ins.rs2_data = ins.rs1_data;
                    else
                    begin
                        ins.rs1_data = (p == 1) ? 32'hffff_fff0 : 32'd16;
                        ins.rs2_data = (p == 1) ? 32'd16 : 32'hffff_fff0;
                    end
                    drive(ins, '0, '0, 1'b0, 1'b0);
                end
            repeat (4) drive(make_instr(rv_types_pkg::JAL, rv_types_pkg::ADD), '0, '0, 0, 0);
            repeat (4) drive(make_instr(rv_types_pkg::JALR, rv_types_pkg::ADD), '0, '0, 0, 0);
            end_test("branch_jump");
            repeat (4)                         // 5 loads, stores, LUI, AUIPC
            begin
                ins = make_instr(rv_types_pkg::MEM, rv_types_pkg::ADD);
                ins.ctrl.mem_read   = 1'b1;
                ins.ctrl.reg_write  = 1'b1;
                ins.ctrl.mem_to_reg = 1'b1;
                drive(ins, '0, '0, 1'b0, 1'b0);
                ins = make_instr(rv_types_pkg::MEM, rv_types_pkg::ADD);
                ins.ctrl.mem_write = 1'b1;
                drive(ins, '0, '0, 1'b0, 1'b0);
                drive(make_instr(rv_types_pkg::LUI, rv_types_pkg::ADD), '0, '0, 1'b0, 1'b0);
                drive(make_instr(rv_types_pkg::AUIPC, rv_types_pkg::ADD), '0, '0, 1'b0, 1'b0);
            end
            end_test("mem_upper");
            repeat (10)                        // 6 held instruction under random stalls
            begin
                drive(make_instr(rv_types_pkg::ARITH, ops[$unsigned($random(seed)) % 11]),
                      rand_fwd(), rand_fwd(), 1'b0, 1'b0);
                t = $random(seed);
                repeat (1 + t[1:0])
                    drive(make_instr(rv_types_pkg::ARITH, rv_types_pkg::XOR),
                          rand_fwd(), rand_fwd(), 1'b1, 1'b0);
            end
            end_test("stall");
            $display("Total: %0d checks, %0d errors", checks, errors);
            if (errors == 0)
                $display("TESTS PASSED");
            else
                $display("TESTS FAILED");
            $finish;
        end
    end

endmodule

//--- sources.f
+incdir+src
src/rv_types_pkg.sv
src/rv_pipe_pkg.sv
src/alu.sv
src/forward_unit.sv
src/execute.sv
src/ex_stage_top.sv
bench/ex_stage_props.sv
bench/ex_stage_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= ex_stage_tb
RTL_TOP   ?= ex_stage_top
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# Pass only when the pass message shows up in the output
sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "TESTS PASSED"

clean:
	rm -rf $(OBJ_DIR)
